//--- sparse_ctrl_defs.svh
`ifndef SPARSE_CTRL_DEFS_SVH
`define SPARSE_CTRL_DEFS_SVH

// --------------------------------------------------------------------
// row geometry
// --------------------------------------------------------------------
`define SC_N_ARRAYS       3
`define SC_PES_PER_ARRAY  4

// event word fields
`define SC_ACT_W          8
`define SC_COL_W          8
`define SC_WORD_W         24
// activation sits in bits 7..0
`define SC_ACT_MSB        7
// toggled column in bits 15..8
`define SC_COL_MSB        15
`define SC_LAST_COL_BIT   16
// bits 23..17 reserved

// weight line buffer, 64 deep
`define SC_WADDR_W        6
// up to 16 kernel steps
`define SC_STEP_W         4

`endif

//--- sparse_ctrl_pkg.sv
`default_nettype none

`include "sparse_ctrl_defs.svh"

package sparse_ctrl_pkg;

    // raw event word from the sparse source
    typedef logic [`SC_WORD_W-1:0] event_word_t;
    // one activation per PE lane
    typedef logic [`SC_ACT_W*`SC_PES_PER_ARRAY-1:0] act_vec_t;
    typedef logic [`SC_COL_W-1:0] column_t;
    typedef logic [`SC_WADDR_W-1:0] weight_addr_t;
    typedef logic [`SC_STEP_W-1:0] step_t;

    // accumulator clear sequence
    typedef enum logic [1:0] {
        WAIT_LAST_COLUMN,
        IN_LAST_COLUMN,
        DRAIN_UPDATE
    } acc_reset_state_t;

endpackage

`default_nettype wire

//--- sparse_event_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "sparse_ctrl_defs.svh"

module sparse_event_decoder import sparse_ctrl_pkg::*; (
    input  wire logic         clk,
    input  wire logic         resetn,
    input  wire event_word_t  i_event_word,
    input  wire logic         i_event_valid,
    input  wire weight_addr_t i_weight_base,
    input  wire logic         i_ready,
    output logic              o_dec_valid,
    output column_t           o_dec_column,
    output logic              o_dec_last_column,
    output act_vec_t          o_dec_activations,
    output weight_addr_t      o_dec_weight_base
);

    // --------------------------------------------------------------------
    // control fields and weight base
    // --------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            o_dec_valid       <= 1'b0;
            o_dec_column      <= '0;
            o_dec_last_column <= 1'b0;
            o_dec_weight_base <= '0;
        end else begin
            // strobe only counts while the source is allowed to send
            o_dec_valid <= i_event_valid && i_ready;
            // fields held while busy, base must stay put for all steps
            if (i_ready) begin
                o_dec_column      <= i_event_word[`SC_COL_MSB -: `SC_COL_W];
                o_dec_last_column <= i_event_word[`SC_LAST_COL_BIT];
                o_dec_weight_base <= i_weight_base;
            end
        end
    end

    // activation broadcast to every PE lane of an array
    always_ff @(posedge clk) begin
        if (i_ready) begin
            o_dec_activations <= {`SC_PES_PER_ARRAY{i_event_word[`SC_ACT_MSB -: `SC_ACT_W]}};
        end
    end

endmodule

`default_nettype wire

//--- kernel_step_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "sparse_ctrl_defs.svh"

module kernel_step_sequencer import sparse_ctrl_pkg::*; (
    input  wire logic         clk,
    input  wire logic         resetn,
    input  wire logic         i_event_valid,
    input  wire step_t        i_kernel_steps_minus_1,
    input  wire weight_addr_t i_dec_weight_base,
    output logic              o_ready,
    output step_t             o_step_count,
    output weight_addr_t      o_weight_addr
);

    logic  accept;
    step_t step_d;

    assign accept = i_event_valid && o_ready;

    // --------------------------------------------------------------------
    // step counter and ready
    // --------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            o_step_count <= '0;
            o_ready      <= 1'b1;
        end else if (accept || o_step_count != '0) begin
            if (o_step_count == i_kernel_steps_minus_1) begin
                // wrap lets the next event in
                o_step_count <= '0;
                o_ready      <= 1'b1;
            end else begin
                o_step_count <= o_step_count + step_t'(1);
                o_ready      <= 1'b0;
            end
        end
    end

    // step lags one cycle to line up with the registered base
    always_ff @(posedge clk) begin
        if (!resetn) begin
            step_d        <= '0;
            o_weight_addr <= '0;
        end else begin
            step_d        <= o_step_count;
            // wraps modulo line buffer depth
            o_weight_addr <= i_dec_weight_base + {{(`SC_WADDR_W-`SC_STEP_W){1'b0}}, step_d};
        end
    end

endmodule

`default_nettype wire

//--- accumulate_shift_control.sv
`timescale 1ns/100ps
`default_nettype none

`include "sparse_ctrl_defs.svh"

module accumulate_shift_control import sparse_ctrl_pkg::*; (
    input  wire logic    clk,
    input  wire logic    resetn,
    input  wire logic    i_dec_valid,
    input  wire column_t i_dec_column,
    input  wire logic    i_dec_last_column,
    input  wire step_t   i_kernel_steps_minus_1,
    output logic         o_shift_partial_result,
    output step_t        o_shift_steps_count,
    output logic         o_shift_finished,
    output logic         o_reset_accumulator,
    output logic         o_update_reg_file
);

    acc_reset_state_t state;
    column_t          prev_column;
    step_t            out_cnt;
    logic             cnt_active;
    logic             cnt_done;
    logic             shift_trigger;

    // new column, or first regular event after the last column
    assign shift_trigger = i_dec_valid &&
                           ((i_dec_column != prev_column) ||
                            (state == IN_LAST_COLUMN && !i_dec_last_column));
    // final output step of the running shift
    assign cnt_done = cnt_active && (out_cnt == i_kernel_steps_minus_1);

    assign o_shift_steps_count = out_cnt;

    // column of the last seen event
    always_ff @(posedge clk) begin
        if (!resetn) begin
            prev_column <= '0;
        end else if (i_dec_valid) begin
            prev_column <= i_dec_column;
        end
    end

    // --------------------------------------------------------------------
    // output steps counter, shift and finished
    // --------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            out_cnt                <= '0;
            cnt_active             <= 1'b0;
            o_shift_partial_result <= 1'b0;
            o_shift_finished       <= 1'b0;
        end else begin
            // one cycle pulse after the last count
            o_shift_finished <= cnt_done;
            if (cnt_done) begin
                out_cnt                <= '0;
                cnt_active             <= 1'b0;
                o_shift_partial_result <= 1'b0;
            end else if (cnt_active) begin
                out_cnt <= out_cnt + step_t'(1);
            end
            // trigger wins over the wrap of the previous count
            if (shift_trigger) begin
                out_cnt                <= '0;
                cnt_active             <= 1'b1;
                o_shift_partial_result <= 1'b1;
            end
        end
    end

    // --------------------------------------------------------------------
    // accumulator clear FSM
    // --------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state               <= WAIT_LAST_COLUMN;
            o_reset_accumulator <= 1'b0;
            o_update_reg_file   <= 1'b0;
        end else begin
            o_update_reg_file <= 1'b0;
            case (state)
                WAIT_LAST_COLUMN: begin
                    if (i_dec_valid && i_dec_last_column) begin
                        state <= IN_LAST_COLUMN;
                    end
                end
                IN_LAST_COLUMN: begin
                    // row finished, clear while its outputs drain
                    if (i_dec_valid && !i_dec_last_column) begin
                        o_reset_accumulator <= 1'b1;
                        state               <= DRAIN_UPDATE;
                    end
                end
                DRAIN_UPDATE: begin
                    // all output steps of the last column are out
                    if (cnt_done) begin
                        o_reset_accumulator <= 1'b0;
                        o_update_reg_file   <= 1'b1;
                        // a last-column event on the final count is kept
                        if (i_dec_valid && i_dec_last_column) begin
                            state <= IN_LAST_COLUMN;
                        end else begin
                            state <= WAIT_LAST_COLUMN;
                        end
                    end
                end
                default: begin
                    state <= WAIT_LAST_COLUMN;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- systolic_distributor.sv
`timescale 1ns/100ps
`default_nettype none

`include "sparse_ctrl_defs.svh"

module systolic_distributor import sparse_ctrl_pkg::*; (
    input  wire logic         clk,
    input  wire logic         resetn,
    input  wire logic         i_dec_valid,
    input  wire act_vec_t     i_dec_activations,
    input  wire weight_addr_t i_weight_addr,
    input  wire step_t        i_step_count,
    input  wire logic         i_shift_partial_result,
    input  wire logic         i_reset_accumulator,
    input  wire step_t        i_shift_steps_count,
    input  wire logic         i_update_reg_file,
    input  wire logic         i_shift_finished,
    output act_vec_t          o_activations          [`SC_N_ARRAYS],
    output logic              o_valid                [`SC_N_ARRAYS],
    output weight_addr_t      o_weight_address       [`SC_N_ARRAYS],
    output step_t             o_kernel_step_index    [`SC_N_ARRAYS],
    output logic              o_shift_partial_result [`SC_N_ARRAYS],
    output logic              o_reset_accumulator    [`SC_N_ARRAYS],
    output step_t             o_shift_steps_count    [`SC_N_ARRAYS],
    output logic              o_update_reg_file      [`SC_N_ARRAYS],
    output logic              o_shift_finished
);

    // decoded data is one cycle ahead of the weight address
    localparam int VALID_ALIGN = 1;
    // raw step count leads the address by two cycles
    localparam int STEP_ALIGN  = 2;

    logic     valid_align [VALID_ALIGN];
    act_vec_t act_align   [VALID_ALIGN];
    step_t    step_align  [STEP_ALIGN];

    // --------------------------------------------------------------------
    // alignment delay lines
    // --------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_align <= '{default: 1'b0};
            step_align  <= '{default: '0};
        end else begin
            valid_align[0] <= i_dec_valid;
            step_align[0]  <= i_step_count;
            for (int i = 1; i < VALID_ALIGN; i++) begin
                valid_align[i] <= valid_align[i-1];
            end
            for (int i = 1; i < STEP_ALIGN; i++) begin
                step_align[i] <= step_align[i-1];
            end
        end
    end

    // activation path, line and chain together
    always_ff @(posedge clk) begin
        act_align[0] <= i_dec_activations;
        for (int i = 1; i < VALID_ALIGN; i++) begin
            act_align[i] <= act_align[i-1];
        end
        o_activations[0] <= act_align[VALID_ALIGN-1];
        for (int i = 1; i < `SC_N_ARRAYS; i++) begin
            o_activations[i] <= o_activations[i-1];
        end
    end

    // --------------------------------------------------------------------
    // systolic chain, one stage per PE array
    // --------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            o_valid                <= '{default: 1'b0};
            o_weight_address       <= '{default: '0};
            o_kernel_step_index    <= '{default: '0};
            o_shift_partial_result <= '{default: 1'b0};
            o_reset_accumulator    <= '{default: 1'b0};
            o_shift_steps_count    <= '{default: '0};
            o_update_reg_file      <= '{default: 1'b0};
            o_shift_finished       <= 1'b0;
        end else begin
            // array 0 entry
            o_valid[0]                <= valid_align[VALID_ALIGN-1];
            o_weight_address[0]       <= i_weight_addr;
            o_kernel_step_index[0]    <= step_align[STEP_ALIGN-1];
            o_shift_partial_result[0] <= i_shift_partial_result;
            o_reset_accumulator[0]    <= i_reset_accumulator;
            o_shift_steps_count[0]    <= i_shift_steps_count;
            o_update_reg_file[0]      <= i_update_reg_file;
            // same timing as array 0
            o_shift_finished          <= i_shift_finished;
            for (int i = 1; i < `SC_N_ARRAYS; i++) begin
                o_valid[i]                <= o_valid[i-1];
                o_weight_address[i]       <= o_weight_address[i-1];
                o_kernel_step_index[i]    <= o_kernel_step_index[i-1];
                o_shift_partial_result[i] <= o_shift_partial_result[i-1];
                o_reset_accumulator[i]    <= o_reset_accumulator[i-1];
                o_shift_steps_count[i]    <= o_shift_steps_count[i-1];
                o_update_reg_file[i]      <= o_update_reg_file[i-1];
            end
        end
    end

endmodule

`default_nettype wire

//--- sparse_conv_control_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "sparse_ctrl_defs.svh"

module sparse_conv_control_top import sparse_ctrl_pkg::*; (
    input  wire logic         clk,
    input  wire logic         resetn,
    input  wire event_word_t  i_event_word,
    input  wire logic         i_event_valid,
    input  wire weight_addr_t i_weight_base,
    input  wire step_t        i_kernel_steps_minus_1,
    output logic              o_ready,
    output act_vec_t          o_activations          [`SC_N_ARRAYS],
    output logic              o_valid                [`SC_N_ARRAYS],
    output weight_addr_t      o_weight_address       [`SC_N_ARRAYS],
    output step_t             o_kernel_step_index    [`SC_N_ARRAYS],
    output logic              o_shift_partial_result [`SC_N_ARRAYS],
    output logic              o_reset_accumulator    [`SC_N_ARRAYS],
    output step_t             o_shift_steps_count    [`SC_N_ARRAYS],
    output logic              o_update_reg_file      [`SC_N_ARRAYS],
    output logic              o_shift_finished
);

    // decoded event
    logic         dec_valid;
    column_t      dec_column;
    logic         dec_last_column;
    act_vec_t     dec_activations;
    weight_addr_t dec_weight_base;
    // step sequencing
    step_t        step_count;
    weight_addr_t weight_addr;
    // accumulator control
    logic         shift_partial_result;
    step_t        shift_steps_count;
    logic         shift_finished;
    logic         reset_accumulator;
    logic         update_reg_file;

    sparse_event_decoder decoder_i (
        .clk               (clk),
        .resetn            (resetn),
        .i_event_word      (i_event_word),
        .i_event_valid     (i_event_valid),
        .i_weight_base     (i_weight_base),
        .i_ready           (o_ready),
        .o_dec_valid       (dec_valid),
        .o_dec_column      (dec_column),
        .o_dec_last_column (dec_last_column),
        .o_dec_activations (dec_activations),
        .o_dec_weight_base (dec_weight_base)
    );

    kernel_step_sequencer sequencer_i (
        .clk                    (clk),
        .resetn                 (resetn),
        .i_event_valid          (i_event_valid),
        .i_kernel_steps_minus_1 (i_kernel_steps_minus_1),
        .i_dec_weight_base      (dec_weight_base),
        .o_ready                (o_ready),
        .o_step_count           (step_count),
        .o_weight_addr          (weight_addr)
    );

    accumulate_shift_control shift_ctrl_i (
        .clk                    (clk),
        .resetn                 (resetn),
        .i_dec_valid            (dec_valid),
        .i_dec_column           (dec_column),
        .i_dec_last_column      (dec_last_column),
        .i_kernel_steps_minus_1 (i_kernel_steps_minus_1),
        .o_shift_partial_result (shift_partial_result),
        .o_shift_steps_count    (shift_steps_count),
        .o_shift_finished       (shift_finished),
        .o_reset_accumulator    (reset_accumulator),
        .o_update_reg_file      (update_reg_file)
    );

    systolic_distributor distributor_i (
        .clk                    (clk),
        .resetn                 (resetn),
        .i_dec_valid            (dec_valid),
        .i_dec_activations      (dec_activations),
        .i_weight_addr          (weight_addr),
        .i_step_count           (step_count),
        .i_shift_partial_result (shift_partial_result),
        .i_reset_accumulator    (reset_accumulator),
        .i_shift_steps_count    (shift_steps_count),
        .i_update_reg_file      (update_reg_file),
        .i_shift_finished       (shift_finished),
        .o_activations          (o_activations),
        .o_valid                (o_valid),
        .o_weight_address       (o_weight_address),
        .o_kernel_step_index    (o_kernel_step_index),
        .o_shift_partial_result (o_shift_partial_result),
        .o_reset_accumulator    (o_reset_accumulator),
        .o_shift_steps_count    (o_shift_steps_count),
        .o_update_reg_file      (o_update_reg_file),
        .o_shift_finished       (o_shift_finished)
    );

endmodule

`default_nettype wire

//--- tb_sparse_conv_control.sv
`timescale 1ns/100ps
`default_nettype none

`include "sparse_ctrl_defs.svh"

module tb_sparse_conv_control import sparse_ctrl_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int N_PER_PHASE = 20;
    // events times (K+8) cycles for K = 1, 3 and 4, plus reset and idle gaps
    localparam int WATCHDOG_NS =
        N_PER_PHASE * ((1 + 8) + (3 + 8) + (4 + 8)) * CLK_PERIOD + 4000;

    // one accepted event as the reference model sees it
    typedef struct packed {
        int                   accept_cyc;
        int                   k;
        logic [`SC_ACT_W-1:0] act;
        weight_addr_t         base;
        logic                 trig;
        logic                 clr;
    } event_rec_t;

    logic         clk;
    logic         resetn;
    event_word_t  i_event_word;
    logic         i_event_valid;
    weight_addr_t i_weight_base;
    step_t        i_kernel_steps_minus_1;
    logic         o_ready;
    act_vec_t     o_activations          [`SC_N_ARRAYS];
    logic         o_valid                [`SC_N_ARRAYS];
    weight_addr_t o_weight_address       [`SC_N_ARRAYS];
    step_t        o_kernel_step_index    [`SC_N_ARRAYS];
    logic         o_shift_partial_result [`SC_N_ARRAYS];
    logic         o_reset_accumulator    [`SC_N_ARRAYS];
    step_t        o_shift_steps_count    [`SC_N_ARRAYS];
    logic         o_update_reg_file      [`SC_N_ARRAYS];
    logic         o_shift_finished;
    // array 0 copies for the properties
    logic         rst0;
    logic         upd0;

    int         seed       = 32'h7c9f4c11;
    int         cyc        = 0;
    int         errors     = 0;
    int         checks     = 0;
    int         busy_left  = 0;
    int         n_accepted = 0;
    int         n_triggers = 0;
    int         n_clears   = 0;
    // model of the column and last-column history
    column_t    prev_col   = '0;
    logic       in_last    = 1'b0;
    event_rec_t pending [$];

    sparse_conv_control_top dut_i (.*);

    assign rst0 = o_reset_accumulator[0];
    assign upd0 = o_update_reg_file[0];

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // rising edges seen so far
    always @(posedge clk) cyc <= cyc + 1;

    // --------------------------------------------------------------------
    // stimulus helpers entered 2 ns after a rising edge
    // --------------------------------------------------------------------
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic send_event(input logic [7:0] column, input logic last_col);
        int rnd;
        rnd = $random(seed);
        // source only sends while ready
        while (!o_ready) begin
            @(posedge clk);
            #2;
        end
        // reserved bits get noise that the DUT must ignore
        i_event_word  = {rnd[30:24], last_col, column, rnd[7:0]};
        i_weight_base = rnd[13:8];
        i_event_valid = 1'b1;
        @(posedge clk);
        #2;
        i_event_valid = 1'b0;
        // idle noise on word and base that the decoder must not pick up
        rnd           = $random(seed);
        i_event_word  = rnd[23:0];
        i_weight_base = rnd[29:24];
    endtask

    task automatic run_phase(input int k, input int n_events);
        int         rnd;
        logic [7:0] column;
        logic       last_col;
        // no count may run while K changes
        idle_cycles(10);
        i_kernel_steps_minus_1 = step_t'(k - 1);
        idle_cycles(2);
        column = 8'h00;
        for (int n = 0; n < n_events; n++) begin
            rnd = $random(seed);
            // about half the events move to a new column
            if (rnd[0]) begin
                column = rnd[15:8];
            end
            last_col = (rnd[3:2] == 2'b00);
            send_event(column, last_col);
            // K of 1 keeps one idle cycle so shift counts never overlap
            idle_cycles(int'(rnd[5:4]) + ((k == 1) ? 1 : 0));
        end
    endtask

    task automatic check_value(input string name, input int idx,
                               input int expected, input int actual);
        checks = checks + 1;
        assert (expected == actual) else begin
            errors = errors + 1;
            $display("[FAIL] %s[%0d] expected %0h actual %0h", name, idx, expected, actual);
        end
    endtask

    // --------------------------------------------------------------------
    // scoreboard sampled mid-cycle where outputs are stable
    // --------------------------------------------------------------------
    always @(negedge clk) begin : scoreboard
        event_rec_t ev;
        int         s;
        int         exp_step;
        int         exp_addr;
        int         exp_cnt;
        logic       covered;
        logic       exp_valid;
        logic       exp_shift;
        logic       exp_rst;
        logic       exp_upd;
        logic       exp_fin;
        if (resetn) begin
            check_value("ready", 0, (busy_left == 0) ? 1 : 0, int'(o_ready));
            exp_fin = 1'b0;
            for (int i = 0; i < `SC_N_ARRAYS; i++) begin
                covered   = 1'b0;
                exp_step  = 0;
                exp_addr  = 0;
                exp_cnt   = 0;
                exp_valid = 1'b0;
                exp_shift = 1'b0;
                exp_rst   = 1'b0;
                exp_upd   = 1'b0;
                foreach (pending[n]) begin
                    ev = pending[n];
                    // step of this event now on array i
                    s = cyc - ev.accept_cyc - 2 - i;
                    if (s >= 0 && s < ev.k) begin
                        covered   = 1'b1;
                        exp_step  = s;
                        exp_addr  = (int'(ev.base) + s) % (1 << `SC_WADDR_W);
                        exp_valid = (s == 0);
                        if (s == 0) begin
                            check_value("activations", i,
                                        int'({`SC_PES_PER_ARRAY{ev.act}}),
                                        int'(o_activations[i]));
                        end
                        if (ev.trig) begin
                            exp_shift = 1'b1;
                            exp_cnt   = s;
                        end
                        if (ev.clr) begin
                            exp_rst = 1'b1;
                        end
                    end
                    // cycle after the last step
                    if (s == ev.k) begin
                        if (ev.clr) begin
                            exp_upd = 1'b1;
                        end
                        if (ev.trig && i == 0) begin
                            exp_fin = 1'b1;
                        end
                    end
                end
                if (covered) begin
                    check_value("kernel_step_index", i, exp_step, int'(o_kernel_step_index[i]));
                    check_value("weight_address", i, exp_addr, int'(o_weight_address[i]));
                end
                check_value("valid", i, int'(exp_valid), int'(o_valid[i]));
                check_value("shift_partial_result", i, int'(exp_shift),
                            int'(o_shift_partial_result[i]));
                check_value("shift_steps_count", i, exp_cnt, int'(o_shift_steps_count[i]));
                check_value("reset_accumulator", i, int'(exp_rst), int'(o_reset_accumulator[i]));
                check_value("update_reg_file", i, int'(exp_upd), int'(o_update_reg_file[i]));
            end
            check_value("shift_finished", 0, int'(exp_fin), int'(o_shift_finished));

            // strobe with ready high is accepted on the next edge
            if (i_event_valid && o_ready) begin
                ev.accept_cyc = cyc + 1;
                ev.k          = int'(i_kernel_steps_minus_1) + 1;
                ev.act        = i_event_word[`SC_ACT_MSB -: `SC_ACT_W];
                ev.base       = i_weight_base;
                ev.clr        = in_last && !i_event_word[`SC_LAST_COL_BIT];
                ev.trig       = (i_event_word[`SC_COL_MSB -: `SC_COL_W] != prev_col) || ev.clr;
                prev_col      = i_event_word[`SC_COL_MSB -: `SC_COL_W];
                in_last       = i_event_word[`SC_LAST_COL_BIT];
                n_accepted    = n_accepted + 1;
                n_triggers    = n_triggers + int'(ev.trig);
                n_clears      = n_clears + int'(ev.clr);
                pending.push_back(ev);
                busy_left     = ev.k - 1;
            end else if (busy_left > 0) begin
                busy_left = busy_left - 1;
            end

            // retire once the last array is past the update cycle
            while (pending.size() > 0 &&
                   cyc - pending[0].accept_cyc - 2 > pending[0].k + `SC_N_ARRAYS) begin
                pending.pop_front();
            end
        end
    end

    // --------------------------------------------------------------------
    // pulse rules on array 0
    // --------------------------------------------------------------------
    finished_single: assert property (@(negedge clk) disable iff (!resetn)
        o_shift_finished |=> !o_shift_finished)
    else begin
        errors = errors + 1;
        $display("[FAIL] shift_finished_repeat expected 0 actual 1");
    end

    update_single: assert property (@(negedge clk) disable iff (!resetn)
        upd0 |=> !upd0)
    else begin
        errors = errors + 1;
        $display("[FAIL] update_reg_file_repeat expected 0 actual 1");
    end

    update_after_reset: assert property (@(negedge clk) disable iff (!resetn)
        upd0 |-> ($past(rst0) && !rst0))
    else begin
        errors = errors + 1;
        $display("update pulse seen without a falling accumulator reset");
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : main
        int end_errors;
        end_errors             = 0;
        resetn                 = 1'b0;
        i_event_word           = '0;
        i_event_valid          = 1'b0;
        i_weight_base          = '0;
        i_kernel_steps_minus_1 = '0;
        repeat (3) @(posedge clk);
        #2;
        resetn = 1'b1;

        run_phase(1, N_PER_PHASE);
        run_phase(3, N_PER_PHASE);
        run_phase(4, N_PER_PHASE);
        // let the last event drain through all arrays
        idle_cycles(16);

        if (n_accepted != 3 * N_PER_PHASE) begin
            end_errors = end_errors + 1;
            $display("only %0d of %0d events were accepted", n_accepted, 3 * N_PER_PHASE);
        end
        if (pending.size() != 0) begin
            end_errors = end_errors + 1;
            $display("events still waiting for outputs at the end of the run");
        end
        if (n_triggers == 0 || n_clears == 0) begin
            end_errors = end_errors + 1;
            $display("stimulus produced no shift trigger or no accumulator reset");
        end
        $display("events %0d  triggers %0d  clears %0d  checks %0d  errors %0d",
                 n_accepted, n_triggers, n_clears, checks, errors + end_errors);
        if (errors + end_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
sparse_ctrl_pkg.sv
sparse_event_decoder.sv
kernel_step_sequencer.sv
accumulate_shift_control.sv
systolic_distributor.sv
sparse_conv_control_top.sv
tb_sparse_conv_control.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_sparse_conv_control
FILELIST  = tb.f
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it, check for the pass line"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -x -F '>>> PASS'

clean:
	rm -rf $(BUILD_DIR)
